// File: Makefile
# Verilator flow for the load/store queue

VERILATOR  ?= verilator
TOP        ?= lsq_tb
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= --lint-only --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/lsq_tb.sv
// Testbench for lsq_top with directed cases and then a random mix from a fixed seed
// Load pops wait until the store side has been quiet for a few cycles
`timescale 1ns/1ps

module lsq_tb import lsq_pkg::*; ();
    localparam int CLK_PERIOD = 40;
    localparam int N_RAND     = 60;
    localparam int N_REQ      = N_RAND + 12;
    // Per-request budget allows for blocked loads waiting on several retires
    localparam int TIMEOUT_NS = (N_REQ * 60 + 800) * CLK_PERIOD;

    typedef struct {
        logic [PAGE_W-1:0]   page;
        logic [OFFSET_W-1:0] offset;
        logic [2:0]          fn3;
        logic [ID_W-1:0]     id;
        bit                  collide;
        int                  nd_older;
    } load_exp_t;

    typedef struct {
        logic [PAGE_W-1:0]   page;
        logic [OFFSET_W-1:0] offset;
        logic [63:0]         data;
        logic [3:0]          be;
        bit                  dbl;
        int                  seq;
    } store_exp_t;

    typedef struct {
        int           seq;
        logic [2:0]   hash;
        bit           discard;
    } store_hist_t;

    logic clk = 1'b0;
    logic rst;
    logic req_push, req_load, req_double;
    logic [OFFSET_W-1:0] req_offset;
    logic [2:0] req_fn3;
    logic [ID_W-1:0] req_id;
    logic [63:0] req_data;
    logic [3:0] req_be;
    logic addr_push, addr_rnw, addr_discard, store_retire;
    logic [PAGE_W-1:0] addr_page;
    logic load_pop = 1'b0;
    logic store_pop = 1'b0;
    logic full, load_valid, store_valid, sq_empty, empty;
    logic [ADDR_W-1:0] load_addr, store_addr;
    logic [2:0] load_fn3;
    logic [ID_W-1:0] load_id;
    logic [DATA_W-1:0] store_data;
    logic [3:0] store_be;

    integer seed = 9882;
    int errors = 0;
    int checks = 0;
    int stores_pushed = 0;
    int nd_stores_pushed = 0;
    int retires = 0;
    int ret_seen = 0;
    int done_nd = 0;
    int loads_done = 0;
    int store_quiet = 0;
    bit st_hi = 0;

    load_exp_t   exp_load[$];
    store_exp_t  exp_store[$];
    store_hist_t store_hist[$];

    lsq_top DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic logic [2:0] hash_ref(input logic [11:0] off);
        return off[11:9] ^ off[8:6] ^ off[5:3];
    endfunction

    function automatic logic [31:0] load_addr_ref(input logic [19:0] page, input logic [11:0] off);
        return {page, off};
    endfunction

    // Expected beat as {addr, data, be}
    function automatic logic [67:0] store_beat_ref(input store_exp_t s, input bit hi);
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  be;
        addr = {s.page, s.offset};
        data = s.data[31:0];
        be   = s.be;
        if (s.dbl) begin
            addr[2] = hi;
            be      = 4'hf;
            if (hi)
                data = s.data[63:32];
        end
        return {addr, data, be};
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Memory side pop pulses
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            load_pop    <= 1'b0;
            store_pop   <= 1'b0;
            store_quiet <= 0;
        end else begin
            // Store pop, retire or push can move the store head or refill the queue
            if (store_pop || store_retire || (req_push && !req_load))
                store_quiet <= 0;
            else if (store_quiet < SQ_DEPTH)
                store_quiet <= store_quiet + 1;
            // Retired discards may leave one per cycle and unblock or block a load
            load_pop  <= !load_pop && load_valid && (store_quiet == SQ_DEPTH)
                         && !store_pop && !store_retire && !(req_push && !req_load)
                         && (($random(seed) & 3) != 0);
            store_pop <= !store_pop && store_valid && (($random(seed) & 3) != 0);
        end
    end

    // Compare process
    always @(posedge clk) begin
        load_exp_t  le;
        store_exp_t se;
        logic [67:0] beat;
        if (!rst) begin
            if (store_retire)
                ret_seen++;
            if (load_pop) begin
                if (!load_valid || exp_load.size() == 0) begin
                    errors++;
                    $display("Load popped at %0t with nothing expected on offer", $time);
                end else begin
                    le = exp_load.pop_front();
                    check_val("load_addr", load_addr, load_addr_ref(le.page, le.offset));
                    check_val("load_fn3", load_fn3, le.fn3);
                    check_val("load_id", load_id, le.id);
                    if (le.collide)
                        check_val("older_stores_done", done_nd >= le.nd_older, 1);
                    loads_done++;
                end
            end
            if (store_pop) begin
                if (!store_valid || exp_store.size() == 0) begin
                    errors++;
                    $display("Store popped at %0t with nothing expected on offer", $time);
                end else begin
                    se   = exp_store[0];
                    beat = store_beat_ref(se, st_hi);
                    check_val("store_addr", store_addr, beat[67:36]);
                    check_val("store_data", store_data, beat[35:4]);
                    check_val("store_be", store_be, beat[3:0]);
                    check_val("store_retired", se.seq < ret_seen, 1);
                    if (se.dbl && !st_hi) begin
                        st_hi = 1;
                    end else begin
                        st_hi = 0;
                        void'(exp_store.pop_front());
                        done_nd++;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////
    task automatic pulse_retire();
        @(posedge clk);
        store_retire <= 1'b1;
        @(posedge clk);
        store_retire <= 1'b0;
        retires++;
    endtask

    // Request followed by its address beat one cycle later
    task automatic send_req(input bit is_load, input logic [11:0] off, input logic [2:0] fn3,
                            input logic [3:0] id, input logic [63:0] data,
                            input logic [3:0] be, input bit dbl,
                            input logic [19:0] page, input bit discard);
        load_exp_t  le;
        store_exp_t se;
        @(posedge clk);
        while (full) begin
            if (retires < stores_pushed)
                pulse_retire();
            else
                @(posedge clk);
        end
        req_push   <= 1'b1;
        req_load   <= is_load;
        req_offset <= off;
        req_fn3    <= fn3;
        req_id     <= id;
        req_data   <= data;
        req_be     <= be;
        req_double <= dbl;
        if (is_load) begin
            le = '{page, off, fn3, id, 0, nd_stores_pushed};
            // Only unretired stores are sure to be queued now
            foreach (store_hist[i])
                if (store_hist[i].seq >= retires && !store_hist[i].discard
                    && store_hist[i].hash == hash_ref(off))
                    le.collide = 1;
            if (!discard)
                exp_load.push_back(le);
        end else begin
            se = '{page, off, data, be, dbl, stores_pushed};
            store_hist.push_back('{stores_pushed, hash_ref(off), discard});
            if (!discard) begin
                exp_store.push_back(se);
                nd_stores_pushed++;
            end
        end
        @(posedge clk);
        req_push     <= 1'b0;
        addr_push    <= 1'b1;
        addr_rnw     <= is_load;
        addr_page    <= page;
        addr_discard <= discard;
        if (!is_load)
            stores_pushed++;
        @(posedge clk);
        addr_push <= 1'b0;
    endtask

    task automatic wait_loads(input int target, input int max_cycles);
        int n;
        n = 0;
        while (loads_done < target && n < max_cycles) begin
            @(posedge clk);
            n++;
        end
        if (loads_done < target) begin
            errors++;
            $display("Load did not issue within %0d cycles", max_cycles);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [11:0] off;
        bit          is_load;
        bit          dbl;
        int          n;
        rst = 1'b1;
        {req_push, req_load, req_double, req_offset, req_fn3, req_id} = '0;
        {req_data, req_be, addr_push, addr_rnw, addr_discard, addr_page} = '0;
        store_retire = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        check_val("empty_after_reset", {full, empty, sq_empty, load_valid, store_valid}, 5'b01100);

        // Non-colliding load passes an unretired store
        send_req(0, 12'h008, 3'd0, 4'd0, 64'h1111_2222_3333_4444, 4'h3, 0, 20'h12345, 0);
        send_req(1, 12'h000, 3'd2, 4'd1, 64'h0, 4'h0, 0, 20'h0abcd, 0);
        wait_loads(1, 30);
        check_val("store_held", done_nd, 0);
        // Fill the store queue with a double among them
        send_req(0, 12'h010, 3'd0, 4'd0, 64'hdead_beef_cafe_f00d, 4'hf, 1, 20'h00111, 0);
        send_req(0, 12'h018, 3'd0, 4'd0, 64'h5, 4'h1, 0, 20'h00222, 1);
        send_req(0, 12'h024, 3'd0, 4'd0, 64'h0123_4567_89ab_cdef, 4'hc, 0, 20'h00333, 0);
        @(posedge clk);
        check_val("full", full, 1);
        repeat (4) pulse_retire();

        // Colliding load waits for the older store
        send_req(0, 12'h040, 3'd0, 4'd0, 64'h77, 4'h1, 0, 20'h00444, 0);
        send_req(1, 12'h040, 3'd4, 4'd2, 64'h0, 4'h0, 0, 20'h00555, 0);
        repeat (20) @(posedge clk);
        check_val("collided_load_held", loads_done, 1);
        pulse_retire();
        wait_loads(2, 40);

        // Random mix
        for (int i = 0; i < N_RAND; i++) begin
            is_load = ($random(seed) & 1) != 0;
            dbl     = !is_load && (($random(seed) & 3) == 0);
            off     = $random(seed);
            if (dbl)
                off[2:0] = 3'b000;
            send_req(is_load, off, $random(seed), i[3:0], {$random(seed), $random(seed)},
                     ($random(seed) & 15) | 4'h1, dbl, $random(seed),
                     ($random(seed) & 7) == 0);
            if (retires < stores_pushed && ($random(seed) & 1))
                pulse_retire();
        end

        // Drain
        n = 0;
        while ((exp_load.size() != 0 || exp_store.size() != 0 || !empty) && n < 2000) begin
            if (retires < stores_pushed)
                pulse_retire();
            else
                @(posedge clk);
            n++;
        end
        repeat (4) @(posedge clk);
        check_val("drained", {exp_load.size() == 0, exp_store.size() == 0}, 2'b11);
        check_val("sq_empty", sq_empty, 1);
        check_val("empty", empty, 1);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired, the run did not finish in %0d ns", TIMEOUT_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: source/load_issue.sv
// Load issue path, purely combinational
// Blocking is by store queue index, so a load never waits on newer stores once clear
`timescale 1ns/1ps

module load_issue import lsq_pkg::*; (
    input  logic              lq_valid,
    input  lq_entry_t         lq_head,
    input  logic              la_valid,
    input  addr_entry_t       la_head,
    addr_beat_if.issue        beat,
    sq_head_if.watch          sq,
    input  logic              load_pop,
    output logic              lq_pop,
    output logic              load_valid,
    output logic [ADDR_W-1:0] load_addr,
    output logic [2:0]        load_fn3,
    output logic [ID_W-1:0]   load_id
);
    addr_entry_t addr_sel;
    logic        addr_ok;
    logic        blocked;
    logic        discard;

    // Queued address first, otherwise the beat arriving now
    always_comb begin
        if (la_valid) begin
            addr_sel = la_head;
        end else begin
            addr_sel.page    = beat.page;
            addr_sel.discard = beat.discard;
        end
    end

    assign addr_ok = la_valid || (beat.push && beat.rnw);

    // Held while an older store with the same hash is still queued
    assign blocked = lq_head.collision && sq.valid && (sq.oldest != lq_head.sq_idx);

    // Faulted load leaves without reaching memory
    assign discard = lq_valid && addr_ok && addr_sel.discard;

    assign load_valid = lq_valid && addr_ok && !addr_sel.discard && !blocked;
    assign lq_pop     = load_pop || discard;

    // Physical address is page over untranslated offset
    assign load_addr = {addr_sel.page, lq_head.offset};
    assign load_fn3  = lq_head.fn3;
    assign load_id   = lq_head.id;

endmodule

// File: source/lsq_fifo.sv
// Synchronous FIFO, DEPTH must be a power of two
// Pop on empty together with push lets the pushed word flow through
`timescale 1ns/1ps

module lsq_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t data_in,
    input  logic     pop,
    output logic     valid,
    output payload_t data_out,
    output logic     full
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t          mem [DEPTH];
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  wr_ptr;
    logic [CNT_W-1:0]  count;

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            // Push and pop together leave the count alone
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= data_in;
    end

    assign valid    = (count != '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign data_out = mem[rd_ptr];

    // Source side must respect full
    a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("push while full");
    // Pop needs a stored word or one arriving this cycle
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> (valid || push))
        else $error("pop while empty");

endmodule

// File: source/lsq_if.sv
// Address beat bus and store queue head bus
// Beats arrive in program order per kind and never ahead of their request
`timescale 1ns/1ps

// Translated address beat, driven straight from the top level ports
interface addr_beat_if import lsq_pkg::*; ();
    logic              push;
    // High for a load address, low for a store address
    logic              rnw;
    logic [PAGE_W-1:0] page;
    logic              discard;

    // Issue paths only look at it for the same-cycle bypass
    modport issue (input push, rnw, page, discard);
endinterface

// Oldest store queue entry and its release
interface sq_head_if import lsq_pkg::*; ();
    logic                valid;
    // Retire pointer has moved past the head
    logic                retired;
    sq_entry_t           entry;
    logic [SQ_IDX_W-1:0] oldest;
    logic                pop;

    modport queue (output valid, retired, entry, oldest, input pop);
    modport issue (input valid, retired, entry, output pop);
    // Load side only tracks where the oldest store sits
    modport watch (input valid, oldest);
endinterface

// File: source/lsq_pkg.sv
// Shared widths, depths and entry layouts for the load/store queue
// SQ_DEPTH must be a power of two and SQ_IDX_W must equal its log2
package lsq_pkg;

    //////////////////////////////////////////////////////////////
    // Widths and depths
    //////////////////////////////////////////////////////////////
    localparam int ADDR_W   = 32;
    localparam int PAGE_W   = 20;
    localparam int OFFSET_W = 12;
    localparam int DATA_W   = 32;
    localparam int ID_W     = 4;
    localparam int LQ_DEPTH = 16;
    localparam int SQ_DEPTH = 4;
    localparam int SQ_IDX_W = 2;
    localparam int HASH_W   = 3;

    //////////////////////////////////////////////////////////////
    // Entry types
    //////////////////////////////////////////////////////////////
    // Queued load, sq_idx is the store slot that follows the load
    typedef struct packed {
        logic [OFFSET_W-1:0] offset;
        logic [2:0]          fn3;
        logic [ID_W-1:0]     id;
        logic                collision;
        logic [SQ_IDX_W-1:0] sq_idx;
    } lq_entry_t;

    // Queued store with its data
    typedef struct packed {
        logic [OFFSET_W-1:0]   offset;
        logic [3:0]            be;
        logic [2*DATA_W-1:0]   data;
        logic                  dbl;
    } sq_entry_t;

    // Translated page, one per access
    typedef struct packed {
        logic [PAGE_W-1:0] page;
        logic              discard;
    } addr_entry_t;

    // Bit 2 is left out so both words of a double share one hash
    function automatic logic [HASH_W-1:0] offset_hash(input logic [OFFSET_W-1:0] offset);
        return offset[11:9] ^ offset[8:6] ^ offset[5:3];
    endfunction

endpackage

// File: source/lsq_top.sv
// In-order load/store queue, requests first and pages later in program order
// Requester must not push while full; memory pops only while the matching valid is high
`timescale 1ns/1ps

module lsq_top import lsq_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    // Requests
    input  logic                req_push,
    input  logic                req_load,
    input  logic [OFFSET_W-1:0] req_offset,
    input  logic [2:0]          req_fn3,
    input  logic [ID_W-1:0]     req_id,
    input  logic [2*DATA_W-1:0] req_data,
    input  logic [3:0]          req_be,
    input  logic                req_double,
    // Translated addresses
    input  logic                addr_push,
    input  logic                addr_rnw,
    input  logic [PAGE_W-1:0]   addr_page,
    input  logic                addr_discard,
    input  logic                store_retire,
    // Memory side
    input  logic                load_pop,
    input  logic                store_pop,
    output logic                full,
    output logic                load_valid,
    output logic [ADDR_W-1:0]   load_addr,
    output logic [2:0]          load_fn3,
    output logic [ID_W-1:0]     load_id,
    output logic                store_valid,
    output logic [ADDR_W-1:0]   store_addr,
    output logic [DATA_W-1:0]   store_data,
    output logic [3:0]          store_be,
    output logic                sq_empty,
    output logic                empty
);
    addr_beat_if beat ();
    sq_head_if   sq_head ();

    logic [HASH_W-1:0]   req_hash;
    logic                conflict;
    logic [SQ_IDX_W-1:0] sq_tail;
    logic                sq_full;
    logic                lq_full;
    lq_entry_t           lq_in;
    sq_entry_t           sq_in;
    addr_entry_t         beat_entry;
    logic                lq_valid;
    lq_entry_t           lq_head;
    logic                la_valid;
    addr_entry_t         la_head;
    logic                sa_valid;
    addr_entry_t         sa_head;
    logic                lq_pop;
    logic                sa_pop;

    ////////////////////////////////////////////////////////////
    // Enqueue
    ////////////////////////////////////////////////////////////
    assign beat.push    = addr_push;
    assign beat.rnw     = addr_rnw;
    assign beat.page    = addr_page;
    assign beat.discard = addr_discard;

    assign req_hash = offset_hash(req_offset);

    // Load remembers the collision and the slot the next store takes
    assign lq_in.offset    = req_offset;
    assign lq_in.fn3       = req_fn3;
    assign lq_in.id        = req_id;
    assign lq_in.collision = conflict;
    assign lq_in.sq_idx    = sq_tail;

    assign sq_in.offset = req_offset;
    assign sq_in.be     = req_be;
    assign sq_in.data   = req_data;
    assign sq_in.dbl    = req_double;

    assign beat_entry.page    = beat.page;
    assign beat_entry.discard = beat.discard;

    // Loads: entry and page FIFOs pop together
    lsq_fifo #(.payload_t(lq_entry_t), .DEPTH(LQ_DEPTH)) u_lq (
        .clk(clk), .rst(rst),
        .push(req_push && req_load), .data_in(lq_in), .pop(lq_pop),
        .valid(lq_valid), .data_out(lq_head), .full(lq_full)
    );

    // Page FIFOs cannot fill, beats never lead their requests
    lsq_fifo #(.payload_t(addr_entry_t), .DEPTH(LQ_DEPTH)) u_la (
        .clk(clk), .rst(rst),
        .push(beat.push && beat.rnw), .data_in(beat_entry), .pop(lq_pop),
        .valid(la_valid), .data_out(la_head), .full()
    );

    lsq_fifo #(.payload_t(addr_entry_t), .DEPTH(SQ_DEPTH)) u_sa (
        .clk(clk), .rst(rst),
        .push(beat.push && !beat.rnw), .data_in(beat_entry), .pop(sa_pop),
        .valid(sa_valid), .data_out(sa_head), .full()
    );

    store_queue u_sq (
        .clk(clk), .rst(rst),
        .push(req_push && !req_load), .entry(sq_in), .retire(store_retire),
        .load_hash(req_hash), .conflict(conflict), .tail(sq_tail),
        .full(sq_full), .empty(sq_empty), .head(sq_head.queue)
    );

    ////////////////////////////////////////////////////////////
    // Issue
    ////////////////////////////////////////////////////////////
    load_issue u_load_issue (
        .lq_valid(lq_valid), .lq_head(lq_head), .la_valid(la_valid), .la_head(la_head),
        .beat(beat.issue), .sq(sq_head.watch), .load_pop(load_pop), .lq_pop(lq_pop),
        .load_valid(load_valid), .load_addr(load_addr), .load_fn3(load_fn3),
        .load_id(load_id)
    );

    store_issue u_store_issue (
        .clk(clk), .rst(rst), .sq(sq_head.issue), .sa_valid(sa_valid), .sa_head(sa_head),
        .beat(beat.issue), .store_pop(store_pop), .sa_pop(sa_pop),
        .store_valid(store_valid), .store_addr(store_addr), .store_data(store_data),
        .store_be(store_be)
    );

    // Either queue full stops all requests
    assign full  = sq_full || lq_full;
    assign empty = !lq_valid && sq_empty;

endmodule

// File: source/store_issue.sv
// Store issue path for retired stores only
// A double leaves as two 32-bit beats, low word first
`timescale 1ns/1ps

module store_issue import lsq_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    sq_head_if.issue          sq,
    input  logic              sa_valid,
    input  addr_entry_t       sa_head,
    addr_beat_if.issue        beat,
    input  logic              store_pop,
    output logic              sa_pop,
    output logic              store_valid,
    output logic [ADDR_W-1:0] store_addr,
    output logic [DATA_W-1:0] store_data,
    output logic [3:0]        store_be
);
    addr_entry_t addr_sel;
    logic        addr_ok;
    logic        ready;
    logic        discard;
    logic        head_pop;
    // Set while the high word of a double is on the output
    logic        high_beat;
    logic        addr_bit2;

    // Queued address, else same-cycle bypass
    always_comb begin
        if (sa_valid) begin
            addr_sel = sa_head;
        end else begin
            addr_sel.page    = beat.page;
            addr_sel.discard = beat.discard;
        end
    end

    assign addr_ok = sa_valid || (beat.push && !beat.rnw);
    assign ready   = sq.valid && sq.retired && addr_ok;
    assign discard = ready && addr_sel.discard;

    assign store_valid = ready && !addr_sel.discard;

    ////////////////////////////////////////////////////////////
    // Double-word split
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst)
            high_beat <= 1'b0;
        else if (store_pop)
            high_beat <= sq.entry.dbl && !high_beat;
    end

    // Head leaves after its last beat
    assign head_pop = store_pop && (!sq.entry.dbl || high_beat);
    assign sq.pop   = head_pop || discard;
    assign sa_pop   = head_pop || discard;

    assign addr_bit2 = sq.entry.dbl ? high_beat : sq.entry.offset[2];

    assign store_addr = {addr_sel.page, sq.entry.offset[11:3], addr_bit2, sq.entry.offset[1:0]};

    // Singles carry their word in the low half
    always_comb begin
        if (sq.entry.dbl && high_beat)
            store_data = sq.entry.data[2*DATA_W-1:DATA_W];
        else
            store_data = sq.entry.data[DATA_W-1:0];
    end

    assign store_be = sq.entry.dbl ? 4'hf : sq.entry.be;

    // Memory side may only take a beat that is on offer
    a_pop_valid: assert property (@(posedge clk) disable iff (rst) store_pop |-> store_valid)
        else $error("store_pop without store_valid");

endmodule

// File: source/store_queue.sv
// Store entries held until retired and then popped by the issue path
// Pointers carry one wrap bit, so SQ_DEPTH must be a power of two
`timescale 1ns/1ps

module store_queue import lsq_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  sq_entry_t           entry,
    input  logic                retire,
    input  logic [HASH_W-1:0]   load_hash,
    output logic                conflict,
    output logic [SQ_IDX_W-1:0] tail,
    output logic                full,
    output logic                empty,
    sq_head_if.queue            head
);
    sq_entry_t           entries [SQ_DEPTH];
    logic [HASH_W-1:0]   hashes  [SQ_DEPTH];
    logic [SQ_DEPTH-1:0] valid_q;

    // Extra top bit tells full from empty
    logic [SQ_IDX_W:0] head_ptr;
    logic [SQ_IDX_W:0] tail_ptr;
    logic [SQ_IDX_W:0] ret_ptr;

    logic [SQ_IDX_W-1:0] head_idx;
    logic [SQ_IDX_W-1:0] tail_idx;

    assign head_idx = head_ptr[SQ_IDX_W-1:0];
    assign tail_idx = tail_ptr[SQ_IDX_W-1:0];

    ////////////////////////////////////////////////////////////
    // Pointers and valid bits
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            ret_ptr  <= '0;
            valid_q  <= '0;
        end else begin
            if (push) begin
                tail_ptr          <= tail_ptr + 1'b1;
                valid_q[tail_idx] <= 1'b1;
            end
            // Retire walks behind the tail, pop walks behind retire
            if (retire)
                ret_ptr <= ret_ptr + 1'b1;
            if (head.pop) begin
                head_ptr          <= head_ptr + 1'b1;
                valid_q[head_idx] <= 1'b0;
            end
        end
    end

    // Payload and hash, written at the tail
    always_ff @(posedge clk) begin
        if (push) begin
            entries[tail_idx] <= entry;
            hashes[tail_idx]  <= offset_hash(entry.offset);
        end
    end

    ////////////////////////////////////////////////////////////
    // Load collision check
    ////////////////////////////////////////////////////////////
    // Any live store with the same hash, retired or not
    always_comb begin
        conflict = 1'b0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (valid_q[i] && (hashes[i] == load_hash))
                conflict = 1'b1;
        end
    end

    assign tail  = tail_idx;
    assign empty = (tail_ptr == head_ptr);
    assign full  = (tail_ptr[SQ_IDX_W] != head_ptr[SQ_IDX_W]) && (tail_idx == head_idx);

    // Head view
    assign head.valid   = !empty;
    assign head.retired = (ret_ptr != head_ptr);
    assign head.entry   = entries[head_idx];
    assign head.oldest  = head_idx;

    // Each retire pulse has to cover a store that is already queued
    a_retire_known: assert property (@(posedge clk) disable iff (rst)
        retire |-> (ret_ptr != tail_ptr))
        else $error("retire with no unretired store");

endmodule

// File: sources.f
source/lsq_pkg.sv
source/lsq_if.sv
source/lsq_fifo.sv
source/store_queue.sv
source/load_issue.sv
source/store_issue.sv
source/lsq_top.sv
dv/lsq_tb.sv
